//--- hdl/mul_cfg_pkg.sv
// Datapath constants and types of the array multiplier, referenced by scoped name from the RTL.
package mul_cfg_pkg;

  // Operand width in bits. Both operands share it.
  localparam int MUL_WIDTH = 16;

  // One adder row per operand bit above bit 0.
  localparam int MUL_ROWS = MUL_WIDTH - 1;

  // Pipeline mask with one bit per adder row.
  // A set bit puts a register stage on that row's outputs.
  // Rows 2, 5, 8, 11 and 14 are registered, so the last row always ends in a register.
  localparam logic [MUL_ROWS-1:0] MUL_PIPE_MASK = 15'b100_1001_0010_0100;

  // Cycles from a launch to its result. Every registered row adds one.
  localparam int MUL_LATENCY = $countones(MUL_PIPE_MASK);

  // One multiplier operand.
  typedef logic [MUL_WIDTH-1:0] operand_t;

  // Full product of two operands.
  typedef logic [2*MUL_WIDTH-1:0] product_t;

  // Running sum carried from one adder row to the next.
  typedef logic [MUL_WIDTH-1:0] row_sum_t;

endpackage

//--- hdl/mul_apb_pkg.sv
// APB register map of the multiplier, with the types, offsets and status layout used by the slave.
package mul_apb_pkg;

  // APB address and data types.
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // Register offsets.
  localparam apb_addr_t REG_OPERANDS = 8'h00; // Write only. A write launches a product.
  localparam apb_addr_t REG_RESULT   = 8'h04; // Read only. A read pops the oldest product.
  localparam apb_addr_t REG_STATUS   = 8'h08; // Read only.
  localparam apb_addr_t REG_CLEAR    = 8'h0C; // Write clears the refused flag.

  // Result FIFO geometry.
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

  // Wide enough to hold 0 to FIFO_DEPTH inclusive.
  typedef logic [2:0] fifo_cnt_t;

  // Field positions in the status word.
  localparam int STAT_CNT_LSB     = 0;  // FIFO count, three bits.
  localparam int STAT_EMPTY_BIT   = 8;
  localparam int STAT_INFL_LSB    = 16; // In-flight count, three bits.
  localparam int STAT_REFUSED_BIT = 24; // Sticky until a write to REG_CLEAR.

endpackage

//--- hdl/mul_array_row.sv
// One ripple-carry row of the array multiplier, instantiated once per operand bit by mul_array.
`timescale 1ns/1ps

module mul_array_row #(
  parameter int row_idx_p   = 0,
  parameter bit pipelined_p = 1'b0
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  v_i,
  input  mul_cfg_pkg::operand_t a_i,
  input  mul_cfg_pkg::operand_t b_i,
  input  mul_cfg_pkg::row_sum_t s_i,
  input  logic                  c_i,
  input  mul_cfg_pkg::product_t prod_i,
  output logic                  v_o,
  output mul_cfg_pkg::operand_t a_o,
  output mul_cfg_pkg::operand_t b_o,
  output mul_cfg_pkg::row_sum_t s_o,
  output logic                  c_o,
  output mul_cfg_pkg::product_t prod_o
);

  localparam int W = mul_cfg_pkg::MUL_WIDTH;

  mul_cfg_pkg::operand_t pp;
  logic [W:0]            sum;
  mul_cfg_pkg::product_t prod_n;

  // Partial product for this row's bit of b.
  assign pp = a_i & {W{b_i[row_idx_p+1]}};

  // The previous row's lowest sum bit is already settled, so the carry and the
  // remaining sum bits move down one place before the new partial product is added.
  assign sum = {1'b0, pp} + {1'b0, c_i, s_i[W-1:1]};

  // This row settles one more low product bit.
  always_comb begin
    prod_n                = prod_i;
    prod_n[row_idx_p + 1] = sum[0];
  end

  if (pipelined_p) begin : g_reg

    // Valid tag of the product held in this stage.
    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        v_o <= 1'b0;
      end else begin
        v_o <= v_i;
      end
    end

    always_ff @(posedge clk_i) begin
      a_o    <= a_i;
      b_o    <= b_i;
      s_o    <= sum[W-1:0];
      c_o    <= sum[W];
      prod_o <= prod_n;
    end

  end else begin : g_comb

    assign v_o    = v_i;
    assign a_o    = a_i;
    assign b_o    = b_i;
    assign s_o    = sum[W-1:0];
    assign c_o    = sum[W]; // Carry out of the row.
    assign prod_o = prod_n;

  end

endmodule

//--- hdl/mul_array.sv
// Pipelined unsigned array multiplier. Chains the adder rows and tags each product with a valid bit.
`timescale 1ns/1ps

module mul_array (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  v_i,
  input  mul_cfg_pkg::operand_t a_i,
  input  mul_cfg_pkg::operand_t b_i,
  output logic                  v_o,
  output mul_cfg_pkg::product_t p_o
);

  localparam int W    = mul_cfg_pkg::MUL_WIDTH;
  localparam int ROWS = mul_cfg_pkg::MUL_ROWS;

  // Index i of each chain is the input of row i, and index ROWS is the array output.
  // The operands stop at the last row, so their chains are one entry shorter.
  mul_cfg_pkg::operand_t a_c    [ROWS];
  mul_cfg_pkg::operand_t b_c    [ROWS];
  mul_cfg_pkg::row_sum_t s_c    [ROWS+1];
  logic                  c_c    [ROWS+1];
  mul_cfg_pkg::product_t prod_c [ROWS+1];
  logic                  v_c    [ROWS+1];

  mul_cfg_pkg::operand_t pp0;

  // Row zero of the array is just the first partial product, with no adder.
  assign pp0 = a_i & {W{b_i[0]}};

  assign a_c[0]    = a_i;
  assign b_c[0]    = b_i;
  assign s_c[0]    = pp0;
  assign c_c[0]    = 1'b0;
  assign prod_c[0] = {{(2*W-1){1'b0}}, pp0[0]}; // Product bit 0 is final already.
  assign v_c[0]    = v_i;

  for (genvar i = 0; i < ROWS; i++) begin : g_row
    if (i < ROWS - 1) begin : g_mid
      mul_array_row #(
        .row_idx_p  (i),
        .pipelined_p(mul_cfg_pkg::MUL_PIPE_MASK[i])
      ) row_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .v_i   (v_c[i]),
        .a_i   (a_c[i]),
        .b_i   (b_c[i]),
        .s_i   (s_c[i]),
        .c_i   (c_c[i]),
        .prod_i(prod_c[i]),
        .v_o   (v_c[i+1]),
        .a_o   (a_c[i+1]),
        .b_o   (b_c[i+1]),
        .s_o   (s_c[i+1]),
        .c_o   (c_c[i+1]),
        .prod_o(prod_c[i+1])
      );
    end else begin : g_last
      // The last row has no successor for its operands.
      mul_array_row #(
        .row_idx_p  (i),
        .pipelined_p(mul_cfg_pkg::MUL_PIPE_MASK[i])
      ) row_i (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .v_i   (v_c[i]),
        .a_i   (a_c[i]),
        .b_i   (b_c[i]),
        .s_i   (s_c[i]),
        .c_i   (c_c[i]),
        .prod_i(prod_c[i]),
        .v_o   (v_c[i+1]),
        .a_o   (),
        .b_o   (),
        .s_o   (s_c[i+1]),
        .c_o   (c_c[i+1]),
        .prod_o(prod_c[i+1])
      );
    end
  end

  // The last sum's bit 0 doubles as product bit W-1, so only the bits below it
  // come from the accumulated chain.
  assign p_o = {c_c[ROWS], s_c[ROWS], prod_c[ROWS][W-2:0]};
  assign v_o = v_c[ROWS];

endmodule

//--- hdl/mul_apb_regs.sv
// APB slave of the multiplier. Launches products, tracks those in flight and queues the results.
`timescale 1ns/1ps

module mul_apb_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mul_apb_pkg::apb_addr_t paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  mul_apb_pkg::apb_data_t pwdata_i,
  output mul_apb_pkg::apb_data_t prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  output logic                   launch_v_o,
  output mul_cfg_pkg::operand_t  launch_a_o,
  output mul_cfg_pkg::operand_t  launch_b_o,
  input  logic                   res_v_i,
  input  mul_cfg_pkg::product_t  res_p_i
);

  localparam int CW = $bits(mul_apb_pkg::fifo_cnt_t);

  logic wr_access;
  logic rd_access;
  logic wr_operands;
  logic rd_result;
  logic launch;
  logic refused;
  logic pop;
  logic fifo_empty;
  logic refused_r;
  logic [CW:0] occupancy;

  mul_apb_pkg::fifo_cnt_t fifo_cnt;
  mul_apb_pkg::fifo_cnt_t infl_cnt;
  mul_apb_pkg::apb_data_t status;

  logic [mul_apb_pkg::FIFO_AW-1:0] wr_ptr;
  logic [mul_apb_pkg::FIFO_AW-1:0] rd_ptr;
  mul_cfg_pkg::product_t           fifo_mem [mul_apb_pkg::FIFO_DEPTH];

  assign pready_o = 1'b1; // No wait states.

  // Writes and pops act only in the access phase.
  assign wr_access   = psel_i & penable_i & pwrite_i;
  assign rd_access   = psel_i & penable_i & ~pwrite_i;
  assign wr_operands = wr_access && (paddr_i == mul_apb_pkg::REG_OPERANDS);
  assign rd_result   = rd_access && (paddr_i == mul_apb_pkg::REG_RESULT);

  // Products already queued plus those still in the array must leave room for one more.
  assign occupancy = {1'b0, fifo_cnt} + {1'b0, infl_cnt};
  assign launch    = wr_operands && (occupancy < (CW+1)'(mul_apb_pkg::FIFO_DEPTH));
  assign refused   = wr_operands && !launch;

  assign fifo_empty = (fifo_cnt == '0);
  assign pop        = rd_result & ~fifo_empty;
  assign pslverr_o  = refused | (rd_result & fifo_empty);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      launch_v_o <= 1'b0;
      infl_cnt   <= '0;
      fifo_cnt   <= '0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      refused_r  <= 1'b0;
    end else begin
      launch_v_o <= launch;
      // A launch and a finishing product in the same cycle leave the count as it is.
      case ({launch, res_v_i})
        2'b10:   infl_cnt <= infl_cnt + 1'b1;
        2'b01:   infl_cnt <= infl_cnt - 1'b1;
        default: infl_cnt <= infl_cnt;
      endcase
      case ({res_v_i, pop})
        2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
        2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
        default: fifo_cnt <= fifo_cnt;
      endcase
      if (res_v_i) wr_ptr <= wr_ptr + 1'b1; // Room was checked at launch time.
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      if (refused) begin
        refused_r <= 1'b1;
      end else if (wr_access && (paddr_i == mul_apb_pkg::REG_CLEAR)) begin
        refused_r <= 1'b0;
      end
    end
  end

  // Operands for the array, valid together with launch_v_o.
  always_ff @(posedge clk_i) begin
    if (launch) begin
      launch_a_o <= pwdata_i[15:0];
      launch_b_o <= pwdata_i[31:16];
    end
  end

  always_ff @(posedge clk_i) begin
    if (res_v_i) fifo_mem[wr_ptr] <= res_p_i;
  end

  always_comb begin
    status                                     = '0;
    status[mul_apb_pkg::STAT_CNT_LSB +: CW]    = fifo_cnt;
    status[mul_apb_pkg::STAT_EMPTY_BIT]        = fifo_empty;
    status[mul_apb_pkg::STAT_INFL_LSB +: CW]   = infl_cnt;
    status[mul_apb_pkg::STAT_REFUSED_BIT]      = refused_r;
  end

  // Read data is zero outside a read access, and for an empty FIFO.
  always_comb begin
    prdata_o = '0;
    if (rd_access) begin
      case (paddr_i)
        mul_apb_pkg::REG_RESULT: if (!fifo_empty) prdata_o = fifo_mem[rd_ptr];
        mul_apb_pkg::REG_STATUS: prdata_o = status;
        default:                 prdata_o = '0;
      endcase
    end
  end

endmodule

//--- hdl/mul_apb_top.sv
// Top level of the APB multiplier. Connects the register block to the pipelined array.
`timescale 1ns/1ps

module mul_apb_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  mul_apb_pkg::apb_addr_t paddr_i,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  mul_apb_pkg::apb_data_t pwdata_i,
  output mul_apb_pkg::apb_data_t prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  // Launch side, one product per pulse.
  logic                  launch_v;
  mul_cfg_pkg::operand_t launch_a;
  mul_cfg_pkg::operand_t launch_b;

  // Result side, in launch order.
  logic                  res_v;
  mul_cfg_pkg::product_t res_p;

  mul_apb_regs regs_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .launch_v_o(launch_v),
    .launch_a_o(launch_a),
    .launch_b_o(launch_b),
    .res_v_i   (res_v),
    .res_p_i   (res_p)
  );

  mul_array array_i (
    .clk_i(clk_i),
    .rst_i(rst_i),
    .v_i  (launch_v),
    .a_i  (launch_a),
    .b_i  (launch_b),
    .v_o  (res_v),
    .p_o  (res_p)
  );

endmodule

//--- verification/mul_apb_tb.sv
// Self-checking testbench for mul_apb_top. Drives APB traffic and compares it against a model.
`timescale 1ns/1ps

module mul_apb_tb;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int WAIT_LIMIT   = 50;  // Longest any single wait may take, in cycles.
  localparam int RANDOM_OPS   = 400;

  logic                   clk_i;
  logic                   rst_i;
  mul_apb_pkg::apb_addr_t paddr_i;
  logic                   psel_i;
  logic                   penable_i;
  logic                   pwrite_i;
  mul_apb_pkg::apb_data_t pwdata_i;
  mul_apb_pkg::apb_data_t prdata_o;
  logic                   pready_o;
  logic                   pslverr_o;

  logic [31:0]           rng_state;
  int unsigned           edge_cnt = 0;  // Rising clock edges seen so far.
  mul_cfg_pkg::product_t exp_q[$];  // Accepted products, oldest first.
  int unsigned           due_q[$];  // Edge at which each product enters the FIFO.
  logic                  refused_m;

  mul_apb_top mul_apb_top_i (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .paddr_i  (paddr_i),
    .psel_i   (psel_i),
    .penable_i(penable_i),
    .pwrite_i (pwrite_i),
    .pwdata_i (pwdata_i),
    .prdata_o (prdata_o),
    .pready_o (pready_o),
    .pslverr_o(pslverr_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD/2) clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped at the first error.");
  endtask

  task automatic check_product(input string name, input mul_cfg_pkg::product_t exp,
                               input mul_cfg_pkg::product_t act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input mul_apb_pkg::apb_data_t exp,
                              input mul_apb_pkg::apb_data_t act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_run($sformatf("[ERROR] %0t %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  // 32-bit xorshift generator.
  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Products whose arrival edge has passed are in the FIFO, the rest are in flight.
  function automatic int fifo_model(input int unsigned now);
    int n;
    n = 0;
    foreach (due_q[i]) begin
      if (due_q[i] <= now) n++;
    end
    return n;
  endfunction

  function automatic mul_apb_pkg::apb_data_t expected_status(input int unsigned now);
    mul_apb_pkg::apb_data_t s;
    int fifo_n;
    int infl_n;
    fifo_n    = fifo_model(now);
    infl_n    = exp_q.size() - fifo_n;
    s         = '0;
    s[2:0]    = fifo_n[2:0];
    s[8]      = (fifo_n == 0);
    s[18:16]  = infl_n[2:0];
    s[24]     = refused_m;
    return s;
  endfunction

  // One setup and one access phase. Outputs are sampled a quarter period into the low phase.
  task automatic apb_access(input logic write, input mul_apb_pkg::apb_addr_t addr,
                            input mul_apb_pkg::apb_data_t wdata,
                            output mul_apb_pkg::apb_data_t rdata, output logic err,
                            output int unsigned acc_edge);
    int waited;
    @(negedge clk_i);
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(negedge clk_i);
    penable_i = 1'b1;
    #(CLK_PERIOD/4);
    waited = 0;
    while (pready_o !== 1'b1) begin
      if (waited >= WAIT_LIMIT) begin
        stop_run("The APB slave never raised PREADY during an access phase.");
      end else begin
        @(negedge clk_i);
        #(CLK_PERIOD/4);
        waited++;
      end
    end
    rdata    = prdata_o;
    err      = pslverr_o;
    acc_edge = edge_cnt + 1; // The access completes at the coming edge.
    @(negedge clk_i);
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic apb_write(input mul_apb_pkg::apb_addr_t addr,
                           input mul_apb_pkg::apb_data_t wdata,
                           output logic err, output int unsigned acc_edge);
    mul_apb_pkg::apb_data_t unused_rdata;
    apb_access(1'b1, addr, wdata, unused_rdata, err, acc_edge);
  endtask

  task automatic apb_read(input mul_apb_pkg::apb_addr_t addr,
                          output mul_apb_pkg::apb_data_t rdata,
                          output logic err, output int unsigned acc_edge);
    apb_access(1'b0, addr, '0, rdata, err, acc_edge);
  endtask

  task automatic launch_pair(input mul_cfg_pkg::operand_t a, input mul_cfg_pkg::operand_t b);
    logic        err;
    int unsigned acc;
    logic        full;
    full = (exp_q.size() >= mul_apb_pkg::FIFO_DEPTH); // Queued plus in flight.
    apb_write(mul_apb_pkg::REG_OPERANDS, {b, a}, err, acc);
    check_err("pslverr_o", full, err);
    if (full) begin
      refused_m = 1'b1;
    end else begin
      exp_q.push_back(mul_cfg_pkg::product_t'(a) * mul_cfg_pkg::product_t'(b));
      due_q.push_back(acc + mul_cfg_pkg::MUL_LATENCY + 1);
    end
  endtask

  task automatic read_result();
    mul_apb_pkg::apb_data_t rdata;
    logic                   err;
    int unsigned            acc;
    apb_read(mul_apb_pkg::REG_RESULT, rdata, err, acc);
    if (fifo_model(acc - 1) == 0) begin
      check_err("pslverr_o", 1'b1, err);
      check_product("prdata_o", '0, rdata);
    end else begin
      check_err("pslverr_o", 1'b0, err);
      check_product("prdata_o", exp_q.pop_front(), rdata);
      void'(due_q.pop_front());
    end
  endtask

  // Returns the FIFO count that the DUT reports, after checking the whole status word.
  task automatic read_status(output int fifo_n);
    mul_apb_pkg::apb_data_t rdata;
    logic                   err;
    int unsigned            acc;
    apb_read(mul_apb_pkg::REG_STATUS, rdata, err, acc);
    check_err("pslverr_o", 1'b0, err);
    check_status("prdata_o", expected_status(acc - 1), rdata);
    fifo_n = int'(rdata[2:0]);
  endtask

  task automatic clear_refused();
    logic        err;
    int unsigned acc;
    apb_write(mul_apb_pkg::REG_CLEAR, '0, err, acc);
    check_err("pslverr_o", 1'b0, err);
    refused_m = 1'b0;
  endtask

  // Polls the status register until n products sit in the FIFO.
  task automatic wait_for_fifo(input int n);
    int fifo_n;
    int tries;
    tries = 0;
    read_status(fifo_n);
    while (fifo_n < n) begin
      if (tries >= WAIT_LIMIT) begin
        stop_run("Launched products did not reach the result FIFO in time.");
      end else begin
        read_status(fifo_n);
        tries++;
      end
    end
  endtask

  initial begin
    int                    fifo_n;
    logic [31:0]           r;
    logic [31:0]           r_b;
    mul_cfg_pkg::operand_t corner_a [5];
    mul_cfg_pkg::operand_t corner_b [5];
    rst_i     = 1'b1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    rng_state = 32'hc81d;
    refused_m = 1'b0;
    corner_a  = '{16'h0000, 16'h0001, 16'hFFFF, 16'hFFFF, 16'h0000};
    corner_b  = '{16'h0000, 16'hFFFF, 16'hFFFF, 16'h0001, 16'hFFFF};
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    read_status(fifo_n); // Empty after reset.
    read_result();

    for (int i = 0; i < 25; i++) begin
      r = next_rand();
      if (i < 5) launch_pair(corner_a[i], corner_b[i]);
      else launch_pair(r[15:0], r[31:16]);
      wait_for_fifo(1);
      read_result();
    end

    for (int i = 0; i < 5; i++) begin
      r = next_rand();
      launch_pair(r[15:0], r[31:16]); // The fifth one is refused.
    end
    read_status(fifo_n);
    wait_for_fifo(4);
    repeat (4) read_result();
    clear_refused();
    read_status(fifo_n);
    read_result();

    for (int i = 0; i < RANDOM_OPS; i++) begin
      r = next_rand();
      case (r[1:0])
        2'd0, 2'd1: begin
          r_b = next_rand();
          launch_pair(r[17:2], r_b[22:7]);
        end
        2'd2:       read_result();
        default: begin
          if (r[4:2] == 3'd0) clear_refused();
          read_status(fifo_n);
        end
      endcase
    end

    wait_for_fifo(exp_q.size()); // Drain what is still in flight.
    while (exp_q.size() > 0) read_result();
    read_status(fifo_n);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- mul_apb_top.f
hdl/mul_cfg_pkg.sv
hdl/mul_apb_pkg.sv
hdl/mul_array_row.sv
hdl/mul_array.sv
hdl/mul_apb_regs.sv
hdl/mul_apb_top.sv
verification/mul_apb_tb.sv

//--- Makefile
# Verilator build and run of the APB multiplier testbench.
# Any variable can be overridden on the command line, e.g. make run BUILD_DIR=build.

VERILATOR ?= verilator
TOP       ?= mul_apb_tb
FILELIST  ?= mul_apb_top.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
EXTRA     ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) $(EXTRA) -j $(JOBS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator's exit status carries pass or fail.
run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
